// ==== hdl/ray_pkg.sv ====
// Widths cover frames up to 640x480 with signed Q8.8 coordinates and 8-bit color channels.
package ray_pkg;

	// Linear pixel index, row-major from 0.
	typedef logic [18:0] pixel_id_t;

	// Signed Q8.8, bit 8 is the lowest integer bit.
	typedef logic signed [15:0] coord_t;

	// Packed RGB with red in the top byte.
	typedef logic [23:0] color_t;

	// Ray generator FSM.
	typedef enum logic {
		GEN_IDLE,
		GEN_RUN
	} gen_state_t;

	// Checker colors for floor rays.
	localparam color_t FLOOR_LIGHT = 24'hd0_d0_c8;
	localparam color_t FLOOR_DARK = 24'h30_30_38;

	// Fixed red and green of the sky, blue follows the ray height.
	localparam logic [7:0] SKY_RED = 8'h40;
	localparam logic [7:0] SKY_GREEN = 8'h90;

endpackage : ray_pkg

// ==== hdl/ray_gen.sv ====
// Emits at most one ray every three clocks; camera inputs are sampled only when start is accepted.
`timescale 1ns/1ps

module ray_gen #(
	parameter int H_RES = 640,
	parameter int V_RES = 480
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  ray_pkg::coord_t    corner_x,
	input  ray_pkg::coord_t    corner_y,
	input  ray_pkg::coord_t    corner_z,
	input  ray_pkg::coord_t    step_x,
	input  ray_pkg::coord_t    step_y,
	input  logic               full,
	output logic               push,
	output ray_pkg::pixel_id_t pixel_id,
	output ray_pkg::coord_t    dir_x,
	output ray_pkg::coord_t    dir_y,
	output ray_pkg::coord_t    dir_z,
	output logic               busy
);
	import ray_pkg::*;

	localparam int COL_W = (H_RES > 1) ? $clog2(H_RES) : 1;
	localparam int ROW_W = (V_RES > 1) ? $clog2(V_RES) : 1;

	gen_state_t state;
	logic [1:0] phase;
	logic [COL_W-1:0] col;
	logic [ROW_W-1:0] row;
	coord_t corner_x_q;
	coord_t step_x_q;
	coord_t step_y_q;
	logic accept;
	logic v2;
	logic last_col;
	logic last_row;

	assign accept = (state == GEN_IDLE) && start;
	// Only phase v2 may emit a ray.
	assign v2 = (phase == 2'd2);
	assign last_col = (col == COL_W'(H_RES - 1));
	assign last_row = (row == ROW_W'(V_RES - 1));
	assign push = (state == GEN_RUN) && v2 && !full;
	assign busy = (state == GEN_RUN);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= GEN_IDLE;
			phase <= 2'd0;
		end else begin
			case (state)
				GEN_IDLE: begin
					if (start) begin
						state <= GEN_RUN;
						phase <= 2'd0;
					end
				end
				GEN_RUN: begin
					// A full FIFO parks the generator in v2.
					if (!v2) begin
						phase <= phase + 2'd1;
					end else if (!full) begin
						phase <= 2'd0;
						if (last_col && last_row) begin
							state <= GEN_IDLE;
						end
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (accept) begin
			col <= '0;
			row <= '0;
		end else if (push) begin
			col <= last_col ? '0 : col + 1'b1;
			row <= last_col ? row + 1'b1 : row;
		end
	end

	// Direction walks incrementally, x across a row and y down the rows.
	always_ff @(posedge clk) begin
		if (accept) begin
			corner_x_q <= corner_x;
			step_x_q <= step_x;
			step_y_q <= step_y;
			dir_x <= corner_x;
			dir_y <= corner_y;
			dir_z <= corner_z;
			pixel_id <= '0;
		end else if (push) begin
			pixel_id <= pixel_id + 1'b1;
			if (last_col) begin
				dir_x <= corner_x_q;
				dir_y <= dir_y - step_y_q;
			end else begin
				dir_x <= dir_x + step_x_q;
			end
		end
	end

	// Pixel id stays in step with the column and row counters.
	a_id_tracks_pos: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> pixel_id == pixel_id_t'(row * H_RES + col));

endmodule : ray_gen

// ==== hdl/ray_fifo.sv ====
// Push while full and pop while empty are protocol errors; such requests are dropped.
`timescale 1ns/1ps

module ray_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               push,
	input  ray_pkg::pixel_id_t pixel_id,
	input  ray_pkg::coord_t    dir_x,
	input  ray_pkg::coord_t    dir_y,
	input  ray_pkg::coord_t    dir_z,
	input  logic               pop,
	output logic               full,
	output logic               empty,
	output ray_pkg::pixel_id_t head_id,
	output ray_pkg::coord_t    head_x,
	output ray_pkg::coord_t    head_y,
	output ray_pkg::coord_t    head_z
);
	import ray_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	pixel_id_t id_mem [FIFO_DEPTH];
	coord_t x_mem [FIFO_DEPTH];
	coord_t y_mem [FIFO_DEPTH];
	coord_t z_mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic rd_en;

	// Pointers wrap at the depth, which need not be a power of two.
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			id_mem[wr_ptr] <= pixel_id;
			x_mem[wr_ptr] <= dir_x;
			y_mem[wr_ptr] <= dir_y;
			z_mem[wr_ptr] <= dir_z;
		end
	end

	// Head is read straight from the array.
	assign head_id = id_mem[rd_ptr];
	assign head_x = x_mem[rd_ptr];
	assign head_y = y_mem[rd_ptr];
	assign head_z = z_mem[rd_ptr];

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule : ray_fifo

// ==== hdl/frame_writer.sv ====
// Expects rays in pixel order from id 0; frame_done marks the write of the last pixel.
`timescale 1ns/1ps

module frame_writer #(
	parameter int PIXEL_TOTAL = 640 * 480
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               empty,
	input  ray_pkg::pixel_id_t head_id,
	input  ray_pkg::coord_t    head_x,
	input  ray_pkg::coord_t    head_y,
	input  ray_pkg::coord_t    head_z,
	input  logic               fb_ready,
	output logic               pop,
	output logic               fb_we,
	output ray_pkg::pixel_id_t fb_addr,
	output ray_pkg::color_t    fb_data,
	output logic               frame_done
);
	import ray_pkg::*;

	pixel_id_t pix_cnt;
	coord_t frame_z;
	color_t shade;
	logic last_pix;

	assign pop = !empty && fb_ready;
	assign last_pix = (pix_cnt == pixel_id_t'(PIXEL_TOTAL - 1));

	// Negative y looks at the floor.
	// Checker squares come from the lowest integer bits of x and y.
	always_comb begin
		if (head_y[15]) begin
			shade = (head_x[8] != head_y[8]) ? FLOOR_LIGHT : FLOOR_DARK;
		end else begin
			shade = {SKY_RED, SKY_GREEN, head_y[7:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fb_we <= 1'b0;
			frame_done <= 1'b0;
			pix_cnt <= '0;
		end else begin
			fb_we <= pop;
			frame_done <= pop && last_pix;
			if (pop) begin
				pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			fb_addr <= head_id;
			fb_data <= shade;
		end
		if (pop && pix_cnt == '0) begin
			frame_z <= head_z;
		end
	end

	// Rays arrive in raster order with none lost or repeated.
	a_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> head_id == pix_cnt);

	// all rays of one frame share the depth of its first ray
	a_frame_depth: assert property (@(posedge clk) disable iff (!rst_n)
		pop && pix_cnt != '0 |-> head_z == frame_z);

endmodule : frame_writer

// ==== hdl/ray_demo_top.sv ====
// One frame per accepted start; fb_ready low stalls the whole pipe without losing rays.
`timescale 1ns/1ps

module ray_demo_top #(
	parameter int H_RES = 640,
	parameter int V_RES = 480,
	parameter int FIFO_DEPTH = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  ray_pkg::coord_t    corner_x,
	input  ray_pkg::coord_t    corner_y,
	input  ray_pkg::coord_t    corner_z,
	input  ray_pkg::coord_t    step_x,
	input  ray_pkg::coord_t    step_y,
	input  logic               fb_ready,
	output logic               fb_we,
	output ray_pkg::pixel_id_t fb_addr,
	output ray_pkg::color_t    fb_data,
	output logic               frame_done,
	output logic               busy
);
	import ray_pkg::*;

	logic push;
	logic full;
	pixel_id_t pixel_id;
	coord_t dir_x;
	coord_t dir_y;
	coord_t dir_z;
	logic pop;
	logic empty;
	pixel_id_t head_id;
	coord_t head_x;
	coord_t head_y;
	coord_t head_z;

	ray_gen #(
		.H_RES(H_RES),
		.V_RES(V_RES)
	) i_ray_gen (
		.clk,
		.rst_n,
		.start,
		.corner_x,
		.corner_y,
		.corner_z,
		.step_x,
		.step_y,
		.full,
		.push,
		.pixel_id,
		.dir_x,
		.dir_y,
		.dir_z,
		.busy
	);

	ray_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_ray_fifo (
		.clk,
		.rst_n,
		.push,
		.pixel_id,
		.dir_x,
		.dir_y,
		.dir_z,
		.pop,
		.full,
		.empty,
		.head_id,
		.head_x,
		.head_y,
		.head_z
	);

	frame_writer #(
		.PIXEL_TOTAL(H_RES * V_RES)
	) i_frame_writer (
		.clk,
		.rst_n,
		.empty,
		.head_id,
		.head_x,
		.head_y,
		.head_z,
		.fb_ready,
		.pop,
		.fb_we,
		.fb_addr,
		.fb_data,
		.frame_done
	);

endmodule : ray_demo_top

// ==== dv/ray_demo_tb.sv ====
// Runs 8x6 frames through a 4-deep FIFO; each test waits for its frame to end before the next.
`timescale 1ns/1ps

module ray_demo_tb;
	import ray_pkg::*;

	localparam int H_RES = 8;
	localparam int V_RES = 6;
	localparam int FIFO_DEPTH = 4;
	localparam int PIXELS = H_RES * V_RES;
	localparam int FRAMES = 4;
	localparam int CLK_PERIOD = 100;
	localparam int LIMIT_CYCLES = 3 * PIXELS * FRAMES * 4 + 500;

	logic clk;
	logic rst_n;
	logic start;
	coord_t corner_x;
	coord_t corner_y;
	coord_t corner_z;
	coord_t step_x;
	coord_t step_y;
	logic fb_ready;
	logic fb_we;
	pixel_id_t fb_addr;
	color_t fb_data;
	logic frame_done;
	logic busy;

	pixel_id_t wr_addr [$];
	color_t wr_data [$];
	int done_count;
	int errors;
	int tests_passed;
	int tests_failed;
	logic [31:0] rng_state;

	ray_demo_top #(
		.H_RES(H_RES),
		.V_RES(V_RES),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_ray_demo_top (
		.clk,
		.rst_n,
		.start,
		.corner_x,
		.corner_y,
		.corner_z,
		.step_x,
		.step_y,
		.fb_ready,
		.fb_we,
		.fb_addr,
		.fb_data,
		.frame_done,
		.busy
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * LIMIT_CYCLES);
		$display("Watchdog expired after %0d cycles before the tests finished", LIMIT_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Direction of a pixel from the camera, then the sky or checker floor color.
	function automatic color_t expect_color(input coord_t cx, input coord_t cy,
		input coord_t sx, input coord_t sy, input int pix);
		coord_t x;
		coord_t y;
		color_t c;
		x = cx + coord_t'((pix % H_RES) * sx);
		y = cy - coord_t'((pix / H_RES) * sy);
		if (y < 0) begin
			c = (x[8] != y[8]) ? FLOOR_LIGHT : FLOOR_DARK;
		end else begin
			c = {SKY_RED, SKY_GREEN, y[7:0]};
		end
		return c;
	endfunction

	task automatic check_id(input string name, input pixel_id_t got, input pixel_id_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_color(input string name, input color_t got, input color_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// Write collector, outputs are registered and settled at the falling edge.
	always @(negedge clk) begin
		if (rst_n && fb_we) begin
			wr_addr.push_back(fb_addr);
			wr_data.push_back(fb_data);
		end
		if (rst_n && frame_done) begin
			done_count++;
			check_bit("fb_we with frame_done", fb_we, 1'b1);
			check_id("fb_addr with frame_done", fb_addr, pixel_id_t'(PIXELS - 1));
		end
	end

	task automatic run_frame(input coord_t cx, input coord_t cy, input coord_t cz,
		input coord_t sx, input coord_t sy, input bit random_ready, input bit restart);
		int cyc;
		wr_addr.delete();
		wr_data.delete();
		done_count = 0;
		@(negedge clk);
		corner_x = cx;
		corner_y = cy;
		corner_z = cz;
		step_x = sx;
		step_y = sy;
		start = 1'b1;
		fb_ready = 1'b1;
		cyc = 0;
		@(negedge clk);
		while (wr_addr.size() < PIXELS) begin
			if (random_ready) begin
				rng_state = xorshift(rng_state);
				fb_ready = (rng_state[1:0] == 2'b00);
			end
			if (restart && cyc == 10) begin
				check_bit("busy at second start", busy, 1'b1);
				start = 1'b1;
			end else begin
				start = 1'b0;
			end
			cyc++;
			@(negedge clk);
		end
		start = 1'b0;
		fb_ready = 1'b1;
		// Long enough for a spurious second frame to show its first writes.
		repeat (30) @(negedge clk);
		check_bit("busy after frame", busy, 1'b0);
		if (wr_addr.size() != PIXELS) begin
			$display("Frame gave %0d writes instead of %0d", wr_addr.size(), PIXELS);
			errors++;
		end
		if (done_count != 1) begin
			$display("frame_done pulsed %0d times in one frame", done_count);
			errors++;
		end
		for (int i = 0; i < PIXELS && i < wr_addr.size(); i++) begin
			check_id("fb_addr", wr_addr[i], pixel_id_t'(i));
			check_color("fb_data", wr_data[i], expect_color(cx, cy, sx, sy, i));
		end
	endtask

	task automatic test_reset_idle();
		int errors_before;
		errors_before = errors;
		check_bit("fb_we", fb_we, 1'b0);
		check_bit("frame_done", frame_done, 1'b0);
		check_bit("busy", busy, 1'b0);
		wr_addr.delete();
		wr_data.delete();
		// Frame buffer accepts writes, so any stray ray would show up.
		fb_ready = 1'b1;
		repeat (40) @(negedge clk);
		check_bit("busy while idle", busy, 1'b0);
		if (wr_addr.size() != 0) begin
			$display("Writes appeared with start held low");
			errors++;
		end
		finish_test("reset_idle", errors_before);
	endtask

	// Rows 0 and 1 are sky, the rest floor with x stepping one checker square per column.
	task automatic test_full_speed();
		int errors_before;
		errors_before = errors;
		run_frame(16'hfc00, 16'h0180, 16'h0100, 16'h0100, 16'h0100, 1'b0, 1'b0);
		finish_test("full_speed", errors_before);
	endtask

	task automatic test_back_pressure();
		int errors_before;
		errors_before = errors;
		run_frame(16'hfc00, 16'h0180, 16'h0100, 16'h0100, 16'h0100, 1'b1, 1'b0);
		finish_test("back_pressure", errors_before);
	endtask

	task automatic test_start_while_busy();
		int errors_before;
		errors_before = errors;
		run_frame(16'hfc00, 16'h0180, 16'h0100, 16'h0100, 16'h0100, 1'b0, 1'b1);
		finish_test("start_while_busy", errors_before);
	endtask

	task automatic test_new_camera();
		int errors_before;
		errors_before = errors;
		run_frame(16'hfe40, 16'h0300, 16'h0200, 16'h0080, 16'h00c0, 1'b0, 1'b0);
		finish_test("new_camera", errors_before);
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		corner_x = '0;
		corner_y = '0;
		corner_z = '0;
		step_x = '0;
		step_y = '0;
		fb_ready = 1'b0;
		done_count = 0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		rng_state = 32'd20;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		test_reset_idle();
		test_full_speed();
		test_back_pressure();
		test_start_while_busy();
		test_new_camera();
		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule : ray_demo_tb

// ==== flist.f ====
hdl/ray_pkg.sv
hdl/ray_gen.sv
hdl/ray_fifo.sv
hdl/frame_writer.sv
hdl/ray_demo_top.sv
dv/ray_demo_tb.sv

// ==== Makefile ====
TOP := ray_demo_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f flist.f
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
